//--- hw/des_pkg.sv
`default_nettype none

package des_pkg;

	// ----------------------------------------
	// Widths and types
	// ----------------------------------------
	localparam int BLOCK_W = 64;
	localparam int HALF_W = 32;
	localparam int KEY_W = 64;
	localparam int CD_W = 28;
	localparam int RKEY_W = 48;
	localparam int NUM_ROUNDS = 16;

	typedef logic [BLOCK_W-1:0] block_t;
	typedef logic [HALF_W-1:0] half_t;
	typedef logic [KEY_W-1:0] key_t;
	typedef logic [CD_W-1:0] cd_t;
	typedef logic [RKEY_W-1:0] round_key_t;
	typedef logic [4:0] round_t;

	typedef enum logic {
		ENCRYPT = 1'b0,
		DECRYPT = 1'b1
	} des_mode_e;

	typedef enum logic [1:0] {
		IDLE = 2'd0,
		ROUND = 2'd1,
		DONE = 2'd2
	} des_state_e;

	typedef struct packed {
		des_mode_e mode;
		block_t data;
		key_t key;
	} des_req_t;

	// Per-cycle command from the control FSM
	typedef struct packed {
		logic load;
		logic step;
		round_t round;
		des_mode_e mode;
	} des_step_t;

	// Left rotation per round, read backwards for decryption
	localparam int SHIFT_SCHEDULE [NUM_ROUNDS] = '{
		1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1
	};

	// ----------------------------------------
	// Permutations
	// ----------------------------------------
	// Entries are 1-based source bits, bit 1 being the MSB
	localparam int IP [BLOCK_W] = '{
		58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
		62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
		57, 49, 41, 33, 25, 17, 9, 1, 59, 51, 43, 35, 27, 19, 11, 3,
		61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7
	};

	localparam int FP [BLOCK_W] = '{
		40, 8, 48, 16, 56, 24, 64, 32, 39, 7, 47, 15, 55, 23, 63, 31,
		38, 6, 46, 14, 54, 22, 62, 30, 37, 5, 45, 13, 53, 21, 61, 29,
		36, 4, 44, 12, 52, 20, 60, 28, 35, 3, 43, 11, 51, 19, 59, 27,
		34, 2, 42, 10, 50, 18, 58, 26, 33, 1, 41, 9, 49, 17, 57, 25
	};

	localparam int E [RKEY_W] = '{
		32, 1, 2, 3, 4, 5, 4, 5, 6, 7, 8, 9,
		8, 9, 10, 11, 12, 13, 12, 13, 14, 15, 16, 17,
		16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25,
		24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32, 1
	};

	localparam int P [HALF_W] = '{
		16, 7, 20, 21, 29, 12, 28, 17, 1, 15, 23, 26, 5, 18, 31, 10,
		2, 8, 24, 14, 32, 27, 3, 9, 19, 13, 30, 6, 22, 11, 4, 25
	};

	// Parity bits 8, 16 .. 64 are skipped
	localparam int PC1 [2*CD_W] = '{
		57, 49, 41, 33, 25, 17, 9, 1, 58, 50, 42, 34, 26, 18,
		10, 2, 59, 51, 43, 35, 27, 19, 11, 3, 60, 52, 44, 36,
		63, 55, 47, 39, 31, 23, 15, 7, 62, 54, 46, 38, 30, 22,
		14, 6, 61, 53, 45, 37, 29, 21, 13, 5, 28, 20, 12, 4
	};

	localparam int PC2 [RKEY_W] = '{
		14, 17, 11, 24, 1, 5, 3, 28, 15, 6, 21, 10,
		23, 19, 12, 4, 26, 8, 16, 7, 27, 20, 13, 2,
		41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48,
		44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
	};

	// ----------------------------------------
	// S-boxes, indexed by row * 16 + column
	// ----------------------------------------
	localparam logic [3:0] SBOX [8][64] = '{
		'{14, 4, 13, 1, 2, 15, 11, 8, 3, 10, 6, 12, 5, 9, 0, 7,
		  0, 15, 7, 4, 14, 2, 13, 1, 10, 6, 12, 11, 9, 5, 3, 8,
		  4, 1, 14, 8, 13, 6, 2, 11, 15, 12, 9, 7, 3, 10, 5, 0,
		  15, 12, 8, 2, 4, 9, 1, 7, 5, 11, 3, 14, 10, 0, 6, 13},
		'{15, 1, 8, 14, 6, 11, 3, 4, 9, 7, 2, 13, 12, 0, 5, 10,
		  3, 13, 4, 7, 15, 2, 8, 14, 12, 0, 1, 10, 6, 9, 11, 5,
		  0, 14, 7, 11, 10, 4, 13, 1, 5, 8, 12, 6, 9, 3, 2, 15,
		  13, 8, 10, 1, 3, 15, 4, 2, 11, 6, 7, 12, 0, 5, 14, 9},
		'{10, 0, 9, 14, 6, 3, 15, 5, 1, 13, 12, 7, 11, 4, 2, 8,
		  13, 7, 0, 9, 3, 4, 6, 10, 2, 8, 5, 14, 12, 11, 15, 1,
		  13, 6, 4, 9, 8, 15, 3, 0, 11, 1, 2, 12, 5, 10, 14, 7,
		  1, 10, 13, 0, 6, 9, 8, 7, 4, 15, 14, 3, 11, 5, 2, 12},
		'{7, 13, 14, 3, 0, 6, 9, 10, 1, 2, 8, 5, 11, 12, 4, 15,
		  13, 8, 11, 5, 6, 15, 0, 3, 4, 7, 2, 12, 1, 10, 14, 9,
		  10, 6, 9, 0, 12, 11, 7, 13, 15, 1, 3, 14, 5, 2, 8, 4,
		  3, 15, 0, 6, 10, 1, 13, 8, 9, 4, 5, 11, 12, 7, 2, 14},
		'{2, 12, 4, 1, 7, 10, 11, 6, 8, 5, 3, 15, 13, 0, 14, 9,
		  14, 11, 2, 12, 4, 7, 13, 1, 5, 0, 15, 10, 3, 9, 8, 6,
		  4, 2, 1, 11, 10, 13, 7, 8, 15, 9, 12, 5, 6, 3, 0, 14,
		  11, 8, 12, 7, 1, 14, 2, 13, 6, 15, 0, 9, 10, 4, 5, 3},
		'{12, 1, 10, 15, 9, 2, 6, 8, 0, 13, 3, 4, 14, 7, 5, 11,
		  10, 15, 4, 2, 7, 12, 9, 5, 6, 1, 13, 14, 0, 11, 3, 8,
		  9, 14, 15, 5, 2, 8, 12, 3, 7, 0, 4, 10, 1, 13, 11, 6,
		  4, 3, 2, 12, 9, 5, 15, 10, 11, 14, 1, 7, 6, 0, 8, 13},
		'{4, 11, 2, 14, 15, 0, 8, 13, 3, 12, 9, 7, 5, 10, 6, 1,
		  13, 0, 11, 7, 4, 9, 1, 10, 14, 3, 5, 12, 2, 15, 8, 6,
		  1, 4, 11, 13, 12, 3, 7, 14, 10, 15, 6, 8, 0, 5, 9, 2,
		  6, 11, 13, 8, 1, 4, 10, 7, 9, 5, 0, 15, 14, 2, 3, 12},
		'{13, 2, 8, 4, 6, 15, 11, 1, 10, 9, 3, 14, 5, 0, 12, 7,
		  1, 15, 13, 8, 10, 3, 7, 4, 12, 5, 6, 11, 0, 14, 9, 2,
		  7, 11, 4, 1, 9, 12, 14, 2, 0, 6, 10, 13, 15, 3, 5, 8,
		  2, 1, 14, 7, 4, 10, 8, 13, 15, 12, 9, 0, 3, 5, 6, 11}
	};

endpackage

`default_nettype wire

//--- hw/des_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module des_ctrl (
	input wire clk,
	input wire rst_n,
	input wire start,
	input wire des_pkg::des_mode_e mode,
	output logic busy,
	output logic done,
	output des_pkg::des_step_t step_ctl
);

	localparam des_pkg::round_t LAST_ROUND = des_pkg::round_t'(des_pkg::NUM_ROUNDS);

	des_pkg::des_state_e state_q;
	des_pkg::round_t round_q;
	des_pkg::des_mode_e mode_q;
	logic accept;

	// A new request is taken whenever no rounds are running
	assign accept = start && (state_q != des_pkg::ROUND);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= des_pkg::IDLE;
			round_q <= '0;
			mode_q <= des_pkg::ENCRYPT;
		end else begin
			unique case (state_q)
				des_pkg::ROUND: begin
					if (round_q == LAST_ROUND) begin
						state_q <= des_pkg::DONE;
						round_q <= '0;
					end else begin
						round_q <= round_q + 1'b1;
					end
				end
				default: begin
					if (accept) begin
						state_q <= des_pkg::ROUND;
						round_q <= 5'd1;
						mode_q <= mode;
					end else begin
						state_q <= des_pkg::IDLE;
					end
				end
			endcase
		end
	end

	assign busy = (state_q == des_pkg::ROUND);
	assign done = (state_q == des_pkg::DONE);

	assign step_ctl = '{
		load: accept,
		step: busy,
		round: round_q,
		mode: mode_q
	};

	// ----------------------------------------
	// Checks
	// ----------------------------------------
	a_round_range: assert property (@(posedge clk) disable iff (!rst_n)
		round_q <= LAST_ROUND);

	// Done is a single-cycle pulse
	a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> !done);

endmodule

`default_nettype wire

//--- hw/des_key_schedule.sv
`timescale 1ns/1ns
`default_nettype none

module des_key_schedule (
	input wire clk,
	input wire rst_n,
	input wire des_pkg::key_t key,
	input wire des_pkg::des_step_t step_ctl,
	output des_pkg::round_key_t round_key
);

	des_pkg::cd_t c_q;
	des_pkg::cd_t d_q;
	des_pkg::cd_t c_rol;
	des_pkg::cd_t d_rol;
	des_pkg::cd_t c_ror;
	des_pkg::cd_t d_ror;
	logic [2*des_pkg::CD_W-1:0] pc1_out;
	logic [2*des_pkg::CD_W-1:0] cd_sel;
	logic [3:0] sh_idx;
	logic shift_two;

	// ----------------------------------------
	// PC1 of the incoming key
	// ----------------------------------------
	always_comb begin
		for (int i = 0; i < 2*des_pkg::CD_W; i++) begin
			pc1_out[2*des_pkg::CD_W-1-i] = key[des_pkg::KEY_W - des_pkg::PC1[i]];
		end
	end

	// Decryption reads the shift table from the far end
	assign sh_idx = (step_ctl.mode == des_pkg::ENCRYPT) ?
		4'(step_ctl.round - 1'b1) : 4'(des_pkg::NUM_ROUNDS - step_ctl.round);
	assign shift_two = (des_pkg::SHIFT_SCHEDULE[sh_idx] == 2);

	assign c_rol = shift_two ? {c_q[25:0], c_q[27:26]} : {c_q[26:0], c_q[27]};
	assign d_rol = shift_two ? {d_q[25:0], d_q[27:26]} : {d_q[26:0], d_q[27]};
	assign c_ror = shift_two ? {c_q[1:0], c_q[27:2]} : {c_q[0], c_q[27:1]};
	assign d_ror = shift_two ? {d_q[1:0], d_q[27:2]} : {d_q[0], d_q[27:1]};

	// Encrypt keys come from the rotated value, decrypt keys from the stored one
	assign cd_sel = (step_ctl.mode == des_pkg::ENCRYPT) ? {c_rol, d_rol} : {c_q, d_q};

	always_comb begin
		for (int i = 0; i < des_pkg::RKEY_W; i++) begin
			round_key[des_pkg::RKEY_W-1-i] = cd_sel[2*des_pkg::CD_W - des_pkg::PC2[i]];
		end
	end

	// ----------------------------------------
	// C/D registers
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			c_q <= '0;
			d_q <= '0;
		end else if (step_ctl.load) begin
			c_q <= pc1_out[2*des_pkg::CD_W-1:des_pkg::CD_W];
			d_q <= pc1_out[des_pkg::CD_W-1:0];
		end else if (step_ctl.step) begin
			if (step_ctl.mode == des_pkg::ENCRYPT) begin
				c_q <= c_rol;
				d_q <= d_rol;
			end else begin
				// Step back to the previous round's halves
				c_q <= c_ror;
				d_q <= d_ror;
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/des_feistel.sv
`timescale 1ns/1ns
`default_nettype none

module des_feistel (
	input wire des_pkg::half_t r_half,
	input wire des_pkg::round_key_t round_key,
	output des_pkg::half_t f_out
);

	logic [des_pkg::RKEY_W-1:0] expanded;
	logic [des_pkg::RKEY_W-1:0] mixed;
	des_pkg::half_t sbox_out;

	// ----------------------------------------
	// Expansion and key mix
	// ----------------------------------------
	always_comb begin
		for (int i = 0; i < des_pkg::RKEY_W; i++) begin
			expanded[des_pkg::RKEY_W-1-i] = r_half[des_pkg::HALF_W - des_pkg::E[i]];
		end
	end

	assign mixed = expanded ^ round_key;

	// ----------------------------------------
	// Eight S-box lookups
	// ----------------------------------------
	always_comb begin : sbox_lookup
		logic [5:0] six;
		six = '0;
		for (int s = 0; s < 8; s++) begin
			six = mixed[des_pkg::RKEY_W-1-6*s -: 6];
			// Outer bits pick the row, inner four the column
			sbox_out[des_pkg::HALF_W-1-4*s -: 4] =
				des_pkg::SBOX[s][{six[5], six[0], six[4:1]}];
		end
	end

	// P permutation
	always_comb begin
		for (int i = 0; i < des_pkg::HALF_W; i++) begin
			f_out[des_pkg::HALF_W-1-i] = sbox_out[des_pkg::HALF_W - des_pkg::P[i]];
		end
	end

endmodule

`default_nettype wire

//--- hw/des_datapath.sv
`timescale 1ns/1ns
`default_nettype none

module des_datapath (
	input wire clk,
	input wire rst_n,
	input wire des_pkg::block_t data,
	input wire des_pkg::des_step_t step_ctl,
	input wire des_pkg::half_t f_out,
	output des_pkg::half_t r_half,
	output des_pkg::block_t result
);

	des_pkg::half_t l_q;
	des_pkg::half_t r_q;
	des_pkg::block_t ip_out;
	des_pkg::block_t preout;

	// ----------------------------------------
	// Initial permutation
	// ----------------------------------------
	always_comb begin
		for (int i = 0; i < des_pkg::BLOCK_W; i++) begin
			ip_out[des_pkg::BLOCK_W-1-i] = data[des_pkg::BLOCK_W - des_pkg::IP[i]];
		end
	end

	// L/R state
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			l_q <= '0;
			r_q <= '0;
		end else if (step_ctl.load) begin
			l_q <= ip_out[des_pkg::BLOCK_W-1:des_pkg::HALF_W];
			r_q <= ip_out[des_pkg::HALF_W-1:0];
		end else if (step_ctl.step) begin
			l_q <= r_q;
			r_q <= l_q ^ f_out;
		end
	end

	assign r_half = r_q;

	// ----------------------------------------
	// Final permutation
	// ----------------------------------------
	// Last round leaves the halves swapped
	assign preout = {r_q, l_q};

	always_comb begin
		for (int i = 0; i < des_pkg::BLOCK_W; i++) begin
			result[des_pkg::BLOCK_W-1-i] = preout[des_pkg::BLOCK_W - des_pkg::FP[i]];
		end
	end

endmodule

`default_nettype wire

//--- hw/des_core.sv
`timescale 1ns/1ns
`default_nettype none

module des_core (
	input wire clk,
	input wire rst_n,
	input wire start,
	input wire des_pkg::des_req_t req,
	output wire busy,
	output wire done,
	output wire des_pkg::block_t result
);

	wire des_pkg::des_step_t step_ctl;
	wire des_pkg::round_key_t round_key;
	wire des_pkg::half_t r_half;
	wire des_pkg::half_t f_out;

	// ----------------------------------------
	// Control
	// ----------------------------------------
	des_ctrl u_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.mode(req.mode),
		.busy(busy),
		.done(done),
		.step_ctl(step_ctl)
	);

	des_key_schedule u_key_schedule (
		.clk(clk),
		.rst_n(rst_n),
		.key(req.key),
		.step_ctl(step_ctl),
		.round_key(round_key)
	);

	// ----------------------------------------
	// Round datapath
	// ----------------------------------------
	des_feistel u_feistel (
		.r_half(r_half),
		.round_key(round_key),
		.f_out(f_out)
	);

	des_datapath u_datapath (
		.clk(clk),
		.rst_n(rst_n),
		.data(req.data),
		.step_ctl(step_ctl),
		.f_out(f_out),
		.r_half(r_half),
		.result(result)
	);

endmodule

`default_nettype wire

//--- dv/des_vectors.svh
`ifndef DES_VECTORS_SVH
`define DES_VECTORS_SVH

// Known-answer DES vectors
// Same index across VEC_KEY, VEC_PT and VEC_CT forms one key, plaintext, ciphertext triple
localparam int NUM_VECTORS = 5;

localparam des_pkg::key_t VEC_KEY [NUM_VECTORS] = '{
	64'h1334_5779_9BBC_DFF1,
	64'h0E32_9232_EA6D_0D73,
	64'h0000_0000_0000_0000,
	64'hFFFF_FFFF_FFFF_FFFF,
	64'h0123_4567_89AB_CDEF
};

localparam des_pkg::block_t VEC_PT [NUM_VECTORS] = '{
	64'h0123_4567_89AB_CDEF,
	64'h8787_8787_8787_8787,
	64'h0000_0000_0000_0000,
	64'hFFFF_FFFF_FFFF_FFFF,
	64'h4E6F_7720_6973_2074
};

localparam des_pkg::block_t VEC_CT [NUM_VECTORS] = '{
	64'h85E8_1354_0F0A_B405,
	64'h0000_0000_0000_0000,
	64'h8CA6_4DE9_C1B1_23A7,
	64'h7359_B216_3E4E_DC58,
	64'h3FA4_0E8A_984D_4815
};

`endif

//--- dv/des_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module des_core_tb;

	`include "des_vectors.svh"

	localparam int CLK_PERIOD = 20;
	localparam int NUM_RANDOM = 8;
	localparam int MAX_EDGES = 40;
	localparam int IDLE_WATCH = 25;
	// Accepting edge plus one edge per round
	localparam int EXP_LATENCY = 17;
	localparam int NUM_OPS = 2*NUM_VECTORS + 2*NUM_RANDOM + 4;
	localparam int WATCHDOG_CYCLES = NUM_OPS*20 + 200;

	logic clk;
	logic rst_n;
	logic start;
	des_pkg::des_req_t req;
	logic busy;
	logic done;
	des_pkg::block_t result;
	int errors;
	int checks;
	integer seed;

	des_core dut (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.req(req),
		.busy(busy),
		.done(done),
		.result(result)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, simulation stopped", WATCHDOG_CYCLES);
		$display("Test failures found");
		$finish;
	end

	// ----------------------------------------
	// Helpers
	// ----------------------------------------
	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	// Leaves the caller at the falling edge after the accepting edge
	task automatic issue(input des_pkg::des_mode_e mode, input des_pkg::key_t key,
			input des_pkg::block_t data);
		@(negedge clk);
		req.mode = mode;
		req.data = data;
		req.key = key;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		// Request is only sampled on the accepting edge
		req = ~req;
	endtask

	task automatic wait_done(input int first, output int edges, output bit busy_ok);
		edges = first;
		busy_ok = 1'b1;
		while (!done && edges < MAX_EDGES) begin
			if (!busy)
				busy_ok = 1'b0;
			@(negedge clk);
			edges++;
		end
		if (!done) begin
			errors++;
			$display("Timed out waiting for done after %0d cycles", edges);
		end
	endtask

	task automatic run_op(input des_pkg::des_mode_e mode, input des_pkg::key_t key,
			input des_pkg::block_t data, output des_pkg::block_t res, output int edges,
			output bit busy_ok);
		issue(mode, key, data);
		wait_done(1, edges, busy_ok);
		res = result;
	endtask

	task automatic count_dones(output int seen);
		seen = 0;
		repeat (IDLE_WATCH) begin
			@(negedge clk);
			if (done)
				seen++;
		end
	endtask

	// ----------------------------------------
	// Directed tests
	// ----------------------------------------
	task automatic test_known_answers();
		des_pkg::block_t res;
		int edges;
		bit busy_ok;
		for (int i = 0; i < NUM_VECTORS; i++) begin
			run_op(des_pkg::ENCRYPT, VEC_KEY[i], VEC_PT[i], res, edges, busy_ok);
			check("encrypt_result", res, VEC_CT[i]);
			run_op(des_pkg::DECRYPT, VEC_KEY[i], VEC_CT[i], res, edges, busy_ok);
			check("decrypt_result", res, VEC_PT[i]);
		end
	endtask

	task automatic test_round_trip();
		des_pkg::key_t key;
		des_pkg::block_t pt;
		des_pkg::block_t ct;
		des_pkg::block_t back;
		int edges;
		bit busy_ok;
		for (int i = 0; i < NUM_RANDOM; i++) begin
			key = {$random(seed), $random(seed)};
			pt = {$random(seed), $random(seed)};
			run_op(des_pkg::ENCRYPT, key, pt, ct, edges, busy_ok);
			run_op(des_pkg::DECRYPT, key, ct, back, edges, busy_ok);
			check("round_trip_result", back, pt);
		end
	endtask

	task automatic test_latency();
		des_pkg::block_t res;
		int edges;
		bit busy_ok;
		run_op(des_pkg::ENCRYPT, VEC_KEY[0], VEC_PT[0], res, edges, busy_ok);
		check("done_latency", edges, EXP_LATENCY);
		check("busy_during_op", busy_ok, 1'b1);
		check("busy_at_done", busy, 1'b0);
		@(negedge clk);
		check("done_after_pulse", done, 1'b0);
		check("busy_after_done", busy, 1'b0);
	endtask

	task automatic test_busy_ignored();
		int edges;
		int extra;
		bit busy_ok;
		issue(des_pkg::ENCRYPT, VEC_KEY[0], VEC_PT[0]);
		repeat (4) @(negedge clk);
		req.mode = des_pkg::DECRYPT;
		req.data = VEC_CT[1];
		req.key = VEC_KEY[1];
		start = 1'b1;
		repeat (3) @(negedge clk);
		start = 1'b0;
		wait_done(8, edges, busy_ok);
		check("busy_op_latency", edges, EXP_LATENCY);
		check("busy_op_result", result, VEC_CT[0]);
		count_dones(extra);
		check("extra_done_count", extra, 0);
	endtask

	task automatic test_reset();
		des_pkg::block_t res;
		int edges;
		int seen;
		bit busy_ok;
		issue(des_pkg::ENCRYPT, VEC_KEY[1], VEC_PT[1]);
		repeat (6) @(negedge clk);
		rst_n = 1'b0;
		@(negedge clk);
		check("busy_in_reset", busy, 1'b0);
		check("done_in_reset", done, 1'b0);
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		count_dones(seen);
		check("done_after_reset", seen, 0);
		check("busy_after_reset", busy, 1'b0);
		// Core must still work after an aborted operation
		run_op(des_pkg::ENCRYPT, VEC_KEY[1], VEC_PT[1], res, edges, busy_ok);
		check("post_reset_result", res, VEC_CT[1]);
	endtask

	initial begin
		errors = 0;
		checks = 0;
		seed = 32'h487e_d1da;
		rst_n = 1'b0;
		start = 1'b0;
		req = '0;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		check("busy_after_por", busy, 1'b0);
		check("done_after_por", done, 1'b0);

		test_known_answers();
		test_round_trip();
		test_latency();
		test_busy_ignored();
		test_reset();

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+dv
hw/des_pkg.sv
hw/des_ctrl.sv
hw/des_key_schedule.sv
hw/des_feistel.sv
hw/des_datapath.sv
hw/des_core.sv
dv/des_core_tb.sv
